// ==== logic/soc_bus_pkg.sv ====
package soc_bus_pkg;

    // bus and RAM geometry
    localparam int XLEN      = 64;
    localparam int WORD_W    = 32;
    localparam int RAM_WORDS = 512;
    localparam int RAM_AW    = $clog2(RAM_WORDS);
    localparam int RAM_LANES = WORD_W / 8;

    // memory map
    localparam logic [XLEN-1:0] RAM_BASE       = 64'h0000_0000_8000_0000;
    localparam logic [XLEN-1:0] RAM_BYTES      = 64'(RAM_WORDS * 4);
    localparam logic [XLEN-1:0] KEY_ADDR       = 64'h0000_0000_1000_0100;
    localparam logic [XLEN-1:0] MTIMECMP_ADDR  = 64'h0000_0000_0200_4000;
    localparam logic [XLEN-1:0] MTIMECMP_RESET = 64'h0000_0000_8000_0000;
    localparam logic [XLEN-1:0] PLIC_BASE      = 64'h0000_0000_0c00_0000;

    // interrupt controller layout, offsets relative to PLIC_BASE
    localparam int PLIC_OFS_W   = 22;
    localparam int PLIC_DW      = 32;
    localparam int PLIC_CTX     = 2;
    localparam int PLIC_SOURCES = 6;
    localparam int PRIO_W       = 3;
    localparam logic [PLIC_OFS_W-1:0] PLIC_PENDING_OFS       = 22'h00_1000;
    localparam logic [PLIC_OFS_W-1:0] PLIC_ENABLE_OFS        = 22'h00_2000;
    localparam logic [PLIC_OFS_W-1:0] PLIC_CTX_ENABLE_STRIDE = 22'h00_0080;
    localparam logic [PLIC_OFS_W-1:0] PLIC_THRESHOLD_OFS     = 22'h20_0000;
    localparam logic [PLIC_OFS_W-1:0] PLIC_CLAIM_OFS         = 22'h20_0004;
    localparam logic [PLIC_OFS_W-1:0] PLIC_CTX_STRIDE        = 22'h00_1000;
    localparam logic [XLEN-1:0]       PLIC_REGION_SIZE       = 64'h0000_0000_0040_0000;

    // load/store encoding as seen on the CPU side
    typedef enum logic [2:0] {
        LS_B  = 3'd0,
        LS_H  = 3'd1,
        LS_W  = 3'd2,
        LS_D  = 3'd3,
        LS_BU = 3'd4,
        LS_HU = 3'd5,
        LS_WU = 3'd6
    } ls_type_e;

    typedef enum logic [2:0] {
        TGT_NONE,
        TGT_RAM,
        TGT_KEY,
        TGT_MTIMECMP,
        TGT_PLIC
    } target_e;

    typedef struct packed {
        logic [XLEN-1:0] address;
        logic [XLEN-1:0] write_data;
        ls_type_e        ls_type;
        logic            read_enable;
        logic            write_enable;
    } bus_req_t;

    typedef struct packed {
        logic [XLEN-1:0] read_data;
        logic            read_done;
        logic            write_done;
    } bus_rsp_t;

    // controller to RAM command
    typedef struct packed {
        logic              stb;
        logic              write;
        logic [RAM_AW-1:0] word_idx;
        logic [1:0]        byte_ofs;
        ls_type_e          ls_type;
        logic [XLEN-1:0]   write_data;
    } ram_req_t;

    typedef struct packed {
        logic [XLEN-1:0] read_data;
        logic            ack;
    } ram_rsp_t;

    typedef struct packed {
        logic                  rd;
        logic                  wr;
        logic [PLIC_OFS_W-1:0] ofs;
        logic [PLIC_DW-1:0]    wdata;
    } plic_req_t;

endpackage

// ==== logic/plic_regs.sv ====
`timescale 1ns/100ps

module plic_regs
    import soc_bus_pkg::*;
(
    input  logic               clock_1hz,
    input  logic               KEY0,
    input  plic_req_t          plic_req,
    output logic [PLIC_DW-1:0] plic_rdata,
    input  logic               irq_source,
    output logic               meip_interrupt,
    output logic               msip_interrupt
);

    localparam int PRIO_IW = $clog2(PLIC_SOURCES);

    logic [PRIO_W-1:0]    prio_q [PLIC_SOURCES];
    logic [PLIC_DW-1:0]   pending_q;
    logic [PLIC_DW-1:0]   enable_q [PLIC_CTX];
    logic [PRIO_W-1:0]    threshold_q [PLIC_CTX];
    logic                 irq_q;
    logic [PLIC_CTX-1:0]  claimable;
    logic [PLIC_CTX-1:0]  en_hit;
    logic [PLIC_CTX-1:0]  thr_hit;
    logic [PLIC_CTX-1:0]  clm_hit;
    logic [PLIC_OFS_W-3:0] src_id;
    logic                 prio_hit;
    logic                 pend_hit;

    // priority entries sit at 4*id below the pending word
    assign src_id   = plic_req.ofs[PLIC_OFS_W-1:2];
    assign prio_hit = (plic_req.ofs < PLIC_PENDING_OFS) && (src_id < PLIC_SOURCES);
    assign pend_hit = (plic_req.ofs == PLIC_PENDING_OFS);

    always_comb begin
        for (int c = 0; c < PLIC_CTX; c++) begin
            en_hit[c]    = plic_req.ofs ==
                           PLIC_ENABLE_OFS + PLIC_OFS_W'(c) * PLIC_CTX_ENABLE_STRIDE;
            thr_hit[c]   = plic_req.ofs == PLIC_THRESHOLD_OFS + PLIC_OFS_W'(c) * PLIC_CTX_STRIDE;
            clm_hit[c]   = plic_req.ofs == PLIC_CLAIM_OFS + PLIC_OFS_W'(c) * PLIC_CTX_STRIDE;
            // only source 1 exists
            claimable[c] = pending_q[1] & enable_q[c][1];
        end
    end

    // unknown offsets read zero
    always_comb begin
        plic_rdata = '0;
        if (prio_hit)
            plic_rdata = PLIC_DW'(prio_q[src_id[PRIO_IW-1:0]]);
        else if (pend_hit)
            plic_rdata = pending_q;
        for (int c = 0; c < PLIC_CTX; c++) begin
            if (en_hit[c])
                plic_rdata = enable_q[c];
            if (thr_hit[c])
                plic_rdata = PLIC_DW'(threshold_q[c]);
            if (clm_hit[c])
                plic_rdata = PLIC_DW'(claimable[c]);
        end
    end

    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            for (int s = 0; s < PLIC_SOURCES; s++)
                prio_q[s] <= '0;
            for (int c = 0; c < PLIC_CTX; c++) begin
                enable_q[c]    <= '0;
                threshold_q[c] <= '0;
            end
            pending_q <= '0;
            irq_q     <= 1'b0;
        end else begin
            irq_q <= irq_source;
            if (plic_req.wr && prio_hit)
                prio_q[src_id[PRIO_IW-1:0]] <= plic_req.wdata[PRIO_W-1:0];
            for (int c = 0; c < PLIC_CTX; c++) begin
                if (plic_req.wr && en_hit[c])
                    enable_q[c] <= plic_req.wdata;
                if (plic_req.wr && thr_hit[c])
                    threshold_q[c] <= plic_req.wdata[PRIO_W-1:0];
                // a successful claim consumes the pending source
                if (plic_req.rd && clm_hit[c] && claimable[c])
                    pending_q[1] <= 1'b0;
            end
            // a new edge wins over a claim in the same cycle
            if (irq_source && !irq_q)
                pending_q[1] <= 1'b1;
        end
    end

    assign meip_interrupt = claimable[0];
    assign msip_interrupt = claimable[1];

endmodule

// ==== logic/ram_port.sv ====
`timescale 1ns/100ps

module ram_port
    import soc_bus_pkg::*;
(
    input  logic     clock_1hz,
    input  logic     KEY0,
    input  ram_req_t ram_req,
    output ram_rsp_t ram_rsp
);

    // shift the addressed lane down, then extend by load type
    function automatic logic [XLEN-1:0] load_extend(input logic [WORD_W-1:0] word,
                                                    input logic [1:0] ofs,
                                                    input ls_type_e ls);
        logic [WORD_W-1:0] sh;
        logic [XLEN-1:0]   res;
        sh = word >> {ofs, 3'b000};
        case (ls)
            LS_B:    res = {{(XLEN-8){sh[7]}}, sh[7:0]};
            LS_BU:   res = {{(XLEN-8){1'b0}}, sh[7:0]};
            LS_H:    res = {{(XLEN-16){sh[15]}}, sh[15:0]};
            LS_HU:   res = {{(XLEN-16){1'b0}}, sh[15:0]};
            LS_W:    res = {{(XLEN-WORD_W){sh[WORD_W-1]}}, sh};
            default: res = {{(XLEN-WORD_W){1'b0}}, sh};
        endcase
        return res;
    endfunction

    function automatic logic [RAM_LANES-1:0] store_lanes(input logic [1:0] ofs,
                                                         input ls_type_e ls);
        logic [RAM_LANES-1:0] be;
        case (ls)
            LS_B:    be = 4'b0001 << ofs;
            LS_H:    be = ofs[1] ? 4'b1100 : 4'b0011;
            default: be = 4'b1111;
        endcase
        return be;
    endfunction

    logic [WORD_W-1:0]    mem [RAM_WORDS];
    logic                 beat_q;
    logic                 ack_q;
    logic [RAM_AW-1:0]    hi_idx_q;
    logic [WORD_W-1:0]    hi_wdata_q;
    logic                 hi_write_q;
    logic [XLEN-1:0]      rdata_q;
    logic [RAM_LANES-1:0] st_lanes;
    logic [WORD_W-1:0]    st_data;
    logic                 is_double;

    assign is_double = (ram_req.ls_type == LS_D);
    assign st_lanes  = store_lanes(ram_req.byte_ofs, ram_req.ls_type);

    // replicate the low bytes across the word, lane enables pick the target
    always_comb begin
        case (ram_req.ls_type)
            LS_B:    st_data = {RAM_LANES{ram_req.write_data[7:0]}};
            LS_H:    st_data = {2{ram_req.write_data[15:0]}};
            default: st_data = ram_req.write_data[WORD_W-1:0];
        endcase
    end

    // a double access takes a second beat before ack
    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            beat_q <= 1'b0;
            ack_q  <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            if (ram_req.stb && is_double) begin
                beat_q <= 1'b1;
            end else if (ram_req.stb) begin
                ack_q <= 1'b1;
            end else if (beat_q) begin
                beat_q <= 1'b0;
                ack_q  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock_1hz) begin
        if (ram_req.stb) begin
            hi_idx_q   <= ram_req.word_idx + 1'b1;
            hi_wdata_q <= ram_req.write_data[XLEN-1:WORD_W];
            hi_write_q <= ram_req.write;
            if (ram_req.write) begin
                for (int b = 0; b < RAM_LANES; b++) begin
                    if (st_lanes[b])
                        mem[ram_req.word_idx][8*b +: 8] <= st_data[8*b +: 8];
                end
            end else if (is_double) begin
                // low word first, high word lands on the next beat
                rdata_q <= {{(XLEN-WORD_W){1'b0}}, mem[ram_req.word_idx]};
            end else begin
                rdata_q <= load_extend(mem[ram_req.word_idx], ram_req.byte_ofs,
                                       ram_req.ls_type);
            end
        end else if (beat_q) begin
            if (hi_write_q)
                mem[hi_idx_q] <= hi_wdata_q;
            else
                rdata_q[XLEN-1:WORD_W] <= mem[hi_idx_q];
        end
    end

    assign ram_rsp.read_data = rdata_q;
    assign ram_rsp.ack       = ack_q;

endmodule

// ==== logic/bus_controller.sv ====
`timescale 1ns/100ps

module bus_controller
    import soc_bus_pkg::*;
(
    input  logic               clock_1hz,
    input  logic               KEY0,
    input  bus_req_t           bus_req,
    output bus_rsp_t           bus_rsp,
    input  logic [7:0]         key_ascii,
    output logic [XLEN-1:0]    mtimecmp,
    output ram_req_t           ram_req,
    input  ram_rsp_t           ram_rsp,
    output plic_req_t          plic_req,
    input  logic [PLIC_DW-1:0] plic_rdata
);

    function automatic target_e decode(input logic [XLEN-1:0] addr);
        target_e tgt;
        tgt = TGT_NONE;
        if (addr >= RAM_BASE && addr < RAM_BASE + RAM_BYTES)
            tgt = TGT_RAM;
        else if (addr == KEY_ADDR)
            tgt = TGT_KEY;
        else if (addr == MTIMECMP_ADDR)
            tgt = TGT_MTIMECMP;
        else if (addr >= PLIC_BASE && addr < PLIC_BASE + PLIC_REGION_SIZE)
            tgt = TGT_PLIC;
        return tgt;
    endfunction

    logic            strobe;
    logic            finish;
    logic            busy_q;
    logic            issue_q;
    logic            write_q;
    target_e         tgt_q;
    logic            read_done_q;
    logic            write_done_q;
    logic            ram_stb_q;
    logic            plic_rd_q;
    logic            plic_wr_q;
    logic [XLEN-1:0] mtimecmp_q;
    logic [XLEN-1:0] read_data_q;
    logic [XLEN-1:0] rd_mux;
    logic [XLEN-1:0] plic_delta;

    assign strobe = bus_req.read_enable | bus_req.write_enable;

    // RAM waits for its ack, everything else finishes right after the issue cycle
    assign finish = busy_q && !issue_q && (tgt_q != TGT_RAM || ram_rsp.ack);

    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            busy_q       <= 1'b0;
            issue_q      <= 1'b0;
            write_q      <= 1'b0;
            tgt_q        <= TGT_NONE;
            read_done_q  <= 1'b1;
            write_done_q <= 1'b1;
            ram_stb_q    <= 1'b0;
            plic_rd_q    <= 1'b0;
            plic_wr_q    <= 1'b0;
            mtimecmp_q   <= MTIMECMP_RESET;
        end else begin
            ram_stb_q <= 1'b0;
            plic_rd_q <= 1'b0;
            plic_wr_q <= 1'b0;
            if (strobe) begin
                busy_q  <= 1'b1;
                issue_q <= 1'b1;
                write_q <= bus_req.write_enable;
                tgt_q   <= decode(bus_req.address);
                if (bus_req.read_enable)
                    read_done_q <= 1'b0;
                if (bus_req.write_enable)
                    write_done_q <= 1'b0;
            end else if (issue_q) begin
                issue_q   <= 1'b0;
                ram_stb_q <= (tgt_q == TGT_RAM);
                plic_rd_q <= (tgt_q == TGT_PLIC) && !write_q;
                plic_wr_q <= (tgt_q == TGT_PLIC) && write_q;
            end else if (finish) begin
                busy_q <= 1'b0;
                if (write_q) begin
                    write_done_q <= 1'b1;
                    if (tgt_q == TGT_MTIMECMP)
                        mtimecmp_q <= bus_req.write_data;
                end else begin
                    read_done_q <= 1'b1;
                end
            end
        end
    end

    // read data steering by the latched target
    always_comb begin
        case (tgt_q)
            TGT_RAM:      rd_mux = ram_rsp.read_data;
            TGT_KEY:      rd_mux = {{(XLEN-8){1'b0}}, key_ascii};
            TGT_MTIMECMP: rd_mux = mtimecmp_q;
            TGT_PLIC:     rd_mux = {{(XLEN-PLIC_DW){1'b0}}, plic_rdata};
            default:      rd_mux = '0;
        endcase
    end

    always_ff @(posedge clock_1hz) begin
        if (finish && !write_q)
            read_data_q <= rd_mux;
    end

    // address and data stay stable on the bus until done, so they go straight through
    assign plic_delta = bus_req.address - PLIC_BASE;

    always_comb begin
        ram_req.stb        = ram_stb_q;
        ram_req.write      = write_q;
        ram_req.word_idx   = bus_req.address[RAM_AW+1:2];
        ram_req.byte_ofs   = bus_req.address[1:0];
        ram_req.ls_type    = bus_req.ls_type;
        ram_req.write_data = bus_req.write_data;
        plic_req.rd        = plic_rd_q;
        plic_req.wr        = plic_wr_q;
        plic_req.ofs       = plic_delta[PLIC_OFS_W-1:0];
        plic_req.wdata     = bus_req.write_data[PLIC_DW-1:0];
    end

    assign bus_rsp.read_data  = read_data_q;
    assign bus_rsp.read_done  = read_done_q;
    assign bus_rsp.write_done = write_done_q;
    assign mtimecmp           = mtimecmp_q;

endmodule

// ==== logic/soc_bus_top.sv ====
`timescale 1ns/100ps

module soc_bus_top
    import soc_bus_pkg::*;
(
    input  logic            clock_1hz,
    input  logic            KEY0,
    input  logic [7:0]      key_ascii,
    input  logic            irq_source,
    input  bus_req_t        bus_req,
    output bus_rsp_t        bus_rsp,
    output logic [XLEN-1:0] mtimecmp,
    output logic            meip_interrupt,
    output logic            msip_interrupt
);

    ram_req_t           ram_req;
    ram_rsp_t           ram_rsp;
    plic_req_t          plic_req;
    logic [PLIC_DW-1:0] plic_rdata;

    bus_controller bus_controller_i (
        .clock_1hz  (clock_1hz),
        .KEY0       (KEY0),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .key_ascii  (key_ascii),
        .mtimecmp   (mtimecmp),
        .ram_req    (ram_req),
        .ram_rsp    (ram_rsp),
        .plic_req   (plic_req),
        .plic_rdata (plic_rdata)
    );

    ram_port ram_port_i (
        .clock_1hz (clock_1hz),
        .KEY0      (KEY0),
        .ram_req   (ram_req),
        .ram_rsp   (ram_rsp)
    );

    plic_regs plic_regs_i (
        .clock_1hz      (clock_1hz),
        .KEY0           (KEY0),
        .plic_req       (plic_req),
        .plic_rdata     (plic_rdata),
        .irq_source     (irq_source),
        .meip_interrupt (meip_interrupt),
        .msip_interrupt (msip_interrupt)
    );

endmodule

// ==== tb/soc_bus_chk.sv ====
`timescale 1ns/100ps

module soc_bus_chk
    import soc_bus_pkg::*;
(
    input logic      clock_1hz,
    input logic      KEY0,
    input bus_req_t  bus_req,
    input bus_rsp_t  bus_rsp,
    input ram_req_t  ram_req,
    input plic_req_t plic_req
);

    logic [2:0] rd_low_cnt;
    logic [2:0] wr_low_cnt;

    // edges on which each done flag was sampled low
    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            rd_low_cnt <= '0;
            wr_low_cnt <= '0;
        end else begin
            rd_low_cnt <= bus_rsp.read_done ? 3'd0 : rd_low_cnt + 3'd1;
            wr_low_cnt <= bus_rsp.write_done ? 3'd0 : wr_low_cnt + 3'd1;
        end
    end

    a_read_fall: assert property (@(posedge clock_1hz) disable iff (!KEY0)
        $fell(bus_rsp.read_done) |-> $past(bus_req.read_enable))
        else $error("read_done fell without a read strobe");

    a_write_fall: assert property (@(posedge clock_1hz) disable iff (!KEY0)
        $fell(bus_rsp.write_done) |-> $past(bus_req.write_enable))
        else $error("write_done fell without a write strobe");

    // at most four cycles low
    a_read_bound: assert property (@(posedge clock_1hz) disable iff (!KEY0)
        rd_low_cnt <= 3'd4)
        else $error("read_done stayed low for more than 4 cycles");

    a_write_bound: assert property (@(posedge clock_1hz) disable iff (!KEY0)
        wr_low_cnt <= 3'd4)
        else $error("write_done stayed low for more than 4 cycles");

    a_strobe_idle: assert property (@(posedge clock_1hz) disable iff (!KEY0)
        (bus_req.read_enable || bus_req.write_enable) |->
        (bus_rsp.read_done && bus_rsp.write_done))
        else $error("bus strobe while an access is still open");

    a_one_target: assert property (@(posedge clock_1hz) disable iff (!KEY0)
        !(ram_req.stb && (plic_req.rd || plic_req.wr)))
        else $error("RAM and interrupt controller strobed together");

endmodule

bind bus_controller soc_bus_chk chk_i (
    .clock_1hz (clock_1hz),
    .KEY0      (KEY0),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp),
    .ram_req   (ram_req),
    .plic_req  (plic_req)
);

// ==== tb/tb_soc_bus.sv ====
`timescale 1ns/100ps

module tb_soc_bus
    import soc_bus_pkg::*;
();

    localparam int MAX_CYCLES = 2000;
    localparam int DONE_LIMIT = 4;
    localparam ls_type_e LOADS [6] = '{LS_W, LS_WU, LS_H, LS_HU, LS_B, LS_BU};

    logic            clock_1hz;
    logic            KEY0;
    logic [7:0]      key_ascii;
    logic            irq_source;
    bus_req_t        bus_req;
    bus_rsp_t        bus_rsp;
    logic [XLEN-1:0] mtimecmp;
    logic            meip_interrupt;
    logic            msip_interrupt;

    // byte-wide reference copy of the RAM
    logic [7:0]  ref_mem [RAM_WORDS*4];
    logic [31:0] lfsr_state = 32'hede64262;
    int          value_errors = 0;
    int          timeout_errors = 0;
    int          cycles = 0;

    soc_bus_top dut_i (.*);

    initial clock_1hz = 1'b0;
    always #20 clock_1hz = ~clock_1hz;

    always @(posedge clock_1hz) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("simulation ran past %0d cycles without finishing", MAX_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [XLEN-1:0] random_bits(input int n);
        logic [XLEN-1:0] v;
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[XLEN-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic int access_bytes(input ls_type_e ls);
        case (ls)
            LS_B, LS_BU: return 1;
            LS_H, LS_HU: return 2;
            LS_W, LS_WU: return 4;
            default:     return 8;
        endcase
    endfunction

    // little endian store into the model
    function automatic void model_store(input logic [XLEN-1:0] addr, input ls_type_e ls,
                                        input logic [XLEN-1:0] data);
        int a;
        int i;
        a = int'(addr - RAM_BASE);
        for (i = 0; i < access_bytes(ls); i++)
            ref_mem[a + i] = data[8*i +: 8];
    endfunction

    // gather the addressed bytes, then sign extend for B, H and W
    function automatic logic [XLEN-1:0] expect_load(input logic [XLEN-1:0] addr,
                                                    input ls_type_e ls);
        logic [XLEN-1:0] v;
        int n;
        int a;
        int i;
        n = access_bytes(ls);
        a = int'(addr - RAM_BASE);
        v = '0;
        for (i = 0; i < n; i++)
            v[8*i +: 8] = ref_mem[a + i];
        if ((ls == LS_B || ls == LS_H || ls == LS_W) && v[8*n-1])
            v = v | ({XLEN{1'b1}} << (8 * n));
        return v;
    endfunction

    function automatic logic [XLEN-1:0] plic_addr(input logic [PLIC_OFS_W-1:0] ofs);
        return PLIC_BASE + 64'(ofs);
    endfunction

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED t=%0t %s expected %h actual %h",
                     $time, name, expected, actual);
            value_errors++;
        end
    endtask

    // ends on the falling edge where done was seen
    task automatic wait_done(input logic is_write);
        int n;
        logic done;
        n = 0;
        done = 1'b0;
        while (!done && n <= DONE_LIMIT) begin
            @(negedge clock_1hz);
            n++;
            done = is_write ? bus_rsp.write_done : bus_rsp.read_done;
        end
        assert (done) else begin
            $display("bus access to %h did not complete within %0d cycles",
                     bus_req.address, DONE_LIMIT);
            timeout_errors++;
        end
    endtask

    task automatic bus_write(input logic [XLEN-1:0] addr, input ls_type_e ls,
                             input logic [XLEN-1:0] data);
        bus_req.address      <= addr;
        bus_req.ls_type      <= ls;
        bus_req.write_data   <= data;
        bus_req.write_enable <= 1'b1;
        @(posedge clock_1hz);
        bus_req.write_enable <= 1'b0;
        wait_done(1'b1);
        @(posedge clock_1hz);
    endtask

    task automatic bus_read(input logic [XLEN-1:0] addr, input ls_type_e ls,
                            output logic [XLEN-1:0] data);
        bus_req.address     <= addr;
        bus_req.ls_type     <= ls;
        bus_req.read_enable <= 1'b1;
        @(posedge clock_1hz);
        bus_req.read_enable <= 1'b0;
        wait_done(1'b0);
        data = bus_rsp.read_data;
        @(posedge clock_1hz);
    endtask

    task automatic check_irq(input logic meip_exp, input logic msip_exp);
        @(negedge clock_1hz);
        check_value("meip_interrupt", 64'(meip_exp), 64'(meip_interrupt));
        check_value("msip_interrupt", 64'(msip_exp), 64'(msip_interrupt));
        @(posedge clock_1hz);
    endtask

    initial begin
        logic [XLEN-1:0] data;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] got;
        int w;
        int k;
        int ofs;
        int c;
        KEY0       = 1'b0;
        key_ascii  = '0;
        irq_source = 1'b0;
        bus_req    = '0;
        repeat (4) @(posedge clock_1hz);
        KEY0 <= 1'b1;
        @(posedge clock_1hz);

        // reset state
        @(negedge clock_1hz);
        check_value("read_done", 64'd1, 64'(bus_rsp.read_done));
        check_value("write_done", 64'd1, 64'(bus_rsp.write_done));
        check_value("mtimecmp", MTIMECMP_RESET, mtimecmp);
        @(posedge clock_1hz);
        check_irq(1'b0, 1'b0);
        bus_read(MTIMECMP_ADDR, LS_D, got);
        check_value("read_data", MTIMECMP_RESET, got);

        // words first, then single bytes and halves on top
        for (w = 0; w < 4; w++) begin
            addr = RAM_BASE + 64'(4 * w);
            data = random_bits(32);
            bus_write(addr, LS_W, data);
            model_store(addr, LS_W, data);
            data = random_bits(8);
            bus_write(addr + 64'(w), LS_B, data);
            model_store(addr + 64'(w), LS_B, data);
            ofs = (w < 2) ? 2 : 0;
            data = random_bits(16);
            bus_write(addr + 64'(ofs), LS_H, data);
            model_store(addr + 64'(ofs), LS_H, data);
        end
        for (w = 0; w < 4; w++) begin
            for (k = 0; k < 6; k++) begin
                for (ofs = 0; ofs < 4; ofs += access_bytes(LOADS[k])) begin
                    addr = RAM_BASE + 64'(4 * w + ofs);
                    bus_read(addr, LOADS[k], got);
                    check_value("read_data", expect_load(addr, LOADS[k]), got);
                end
            end
        end

        // double store, low word sits at the lower address
        addr = RAM_BASE + 64'h40;
        data = random_bits(64);
        bus_write(addr, LS_D, data);
        model_store(addr, LS_D, data);
        bus_read(addr, LS_D, got);
        check_value("read_data", data, got);
        bus_read(addr, LS_WU, got);
        check_value("read_data", {32'b0, data[31:0]}, got);
        bus_read(addr + 64'd4, LS_WU, got);
        check_value("read_data", {32'b0, data[63:32]}, got);

        data = random_bits(8);
        key_ascii <= data[7:0];
        bus_read(KEY_ADDR, LS_BU, got);
        check_value("read_data", {56'b0, data[7:0]}, got);
        data = random_bits(64);
        bus_write(MTIMECMP_ADDR, LS_D, data);
        @(negedge clock_1hz);
        check_value("mtimecmp", data, mtimecmp);
        @(posedge clock_1hz);
        bus_read(MTIMECMP_ADDR, LS_D, got);
        check_value("read_data", data, got);
        // nothing mapped here
        bus_write(64'h0000_0000_4000_0000, LS_W, random_bits(32));
        bus_read(64'h0000_0000_4000_0000, LS_W, got);
        check_value("read_data", 64'd0, got);

        // one context at a time, source 1 only
        for (c = 0; c < 2; c++) begin
            bus_write(plic_addr(PLIC_ENABLE_OFS + 22'(c) * PLIC_CTX_ENABLE_STRIDE),
                      LS_W, 64'h2);
            check_irq(1'b0, 1'b0);
            irq_source <= 1'b1;
            @(posedge clock_1hz);
            irq_source <= 1'b0;
            check_irq(c == 0, c == 1);
            bus_read(plic_addr(PLIC_PENDING_OFS), LS_WU, got);
            check_value("read_data", 64'h2, got);
            bus_read(plic_addr(PLIC_CLAIM_OFS + 22'(c) * PLIC_CTX_STRIDE), LS_WU, got);
            check_value("read_data", 64'd1, got);
            check_irq(1'b0, 1'b0);
            bus_read(plic_addr(PLIC_CLAIM_OFS + 22'(c) * PLIC_CTX_STRIDE), LS_WU, got);
            check_value("read_data", 64'd0, got);
            bus_write(plic_addr(PLIC_ENABLE_OFS + 22'(c) * PLIC_CTX_ENABLE_STRIDE),
                      LS_W, 64'h0);
            data = random_bits(32);
            bus_write(plic_addr(PLIC_THRESHOLD_OFS + 22'(c) * PLIC_CTX_STRIDE), LS_W, data);
            bus_read(plic_addr(PLIC_THRESHOLD_OFS + 22'(c) * PLIC_CTX_STRIDE), LS_WU, got);
            check_value("read_data", 64'(data[PRIO_W-1:0]), got);
        end
        data = random_bits(32);
        bus_write(plic_addr(22'h4), LS_W, data);
        bus_read(plic_addr(22'h4), LS_WU, got);
        check_value("read_data", 64'(data[PRIO_W-1:0]), got);

        $display("value check errors: %0d, bus timeouts: %0d", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// ==== project.f ====
logic/soc_bus_pkg.sv
logic/plic_regs.sv
logic/ram_port.sv
logic/bus_controller.sv
logic/soc_bus_top.sv
tb/soc_bus_chk.sv
tb/tb_soc_bus.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then search the log for the pass line
verilator --binary --timing --assert -Wno-fatal --top-module tb_soc_bus \
    -f project.f -o tb_soc_bus > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_soc_bus > sim.log 2>&1 || echo "simulator exited with an error"
grep -q "^Regression passed$" sim.log && echo "simulation ok" \
    || { echo "simulation failed, see sim.log"; exit 1; }
